//--- hdl/sample_buf_pkg.sv
package sample_buf_pkg;

	//////////////////////////////////////////////////
	// array geometry
	localparam int NUM_CH   = 16;              // readout channels
	localparam int NUM_GRP  = 6;               // parallel input groups
	localparam int SMP_W    = 12;              // one adc sample
	localparam int GRP_W    = NUM_CH * SMP_W;  // 192 bit group bus
	localparam int SEL_W    = 3;               // group select
	localparam int SMPIDX_W = 7;               // sample index and samp_max

	//////////////////////////////////////////////////
	// buffer depths
	localparam int CH_DEPTH  = 1024;
	localparam int HDR_DEPTH = 16;
	localparam int MAX_OPEN  = 15;   // open events tracked at once

	//////////////////////////////////////////////////
	// event header layout
	localparam int HDR_W         = 43;
	localparam int HDR_L1A_LSB   = 0;
	localparam int HDR_L1A_W     = 24;
	localparam int HDR_MATCH_LSB = 24;
	localparam int HDR_MATCH_W   = 12;
	localparam int HDR_OPEN_LSB  = 36;
	localparam int HDR_OPEN_W    = 4;
	localparam int HDR_PHASE_BIT = 40;
	localparam int HDR_OVLP_BIT  = 41;
	localparam int HDR_MOVLP_BIT = 42;

	// load sequencer states
	localparam logic ST_IDLE    = 1'b0;
	localparam logic ST_CAPTURE = 1'b1;

endpackage

//--- hdl/capture_if.sv
interface capture_if;

	logic [sample_buf_pkg::SEL_W-1:0]    sel;         // group being written
	logic                                wr_en;       // channel fifo write strobe
	logic [sample_buf_pkg::SMPIDX_W-1:0] sample_idx;  // sample within event
	logic                                active;      // event capture in progress
	logic                                done;        // last write of event

	modport seq (
		output sel,
		output wr_en,
		output sample_idx,
		output active,
		output done
	);

	modport sink (
		input sel,
		input wr_en
	);

	modport mon (
		input active,
		input done
	);

endinterface

//--- hdl/sync_fifo.sv
module sync_fifo #(
	parameter int WIDTH = 12,
	parameter int DEPTH = 16
) (
	input  logic             CLK40,
	input  logic             srst,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] din,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             full,
	output logic             overflow
);

	logic [WIDTH-1:0]           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;   // occupancy
	logic                       do_wr;
	logic                       do_rd;

	assign empty = (count == 0);
	assign full  = (count == DEPTH);
	assign do_wr = wr_en & ~full;   // writes into a full buffer are lost
	assign do_rd = rd_en & ~empty;
	assign dout  = mem[rd_ptr];     // head is always presented

	always_ff @(posedge CLK40) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge CLK40 or posedge srst) begin
		if (srst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (wr_en && full) begin
				overflow <= 1'b1;   // sticky until srst
			end
		end
	end

	//////////////////////////////////////////////////
	// checks

	// pointer distance and occupancy must stay consistent
	a_count_bound: assert property (
		@(posedge CLK40) disable iff (srst)
		count <= DEPTH
	) else $error("fifo occupancy above depth");

endmodule

//--- hdl/load_fsm.sv
module load_fsm (
	input  logic                                CLK40,
	input  logic                                srst,
	input  logic                                evt_start,
	input  logic [sample_buf_pkg::SMPIDX_W-1:0] samp_max,
	capture_if.seq                              cap
);

	logic state;
	logic last_grp;   // sel on final group
	logic last_smp;   // sample index at samp_max

	assign last_grp = (cap.sel == sample_buf_pkg::NUM_GRP - 1);
	assign last_smp = (cap.sample_idx == samp_max);

	assign cap.active = (state == sample_buf_pkg::ST_CAPTURE);
	assign cap.wr_en  = cap.active;   // one word per cycle while capturing
	assign cap.done   = cap.wr_en & last_grp & last_smp;

	//////////////////////////////////////////////////
	// group / sample stepping

	always_ff @(posedge CLK40 or posedge srst) begin
		if (srst) begin
			state          <= sample_buf_pkg::ST_IDLE;
			cap.sel        <= '0;
			cap.sample_idx <= '0;
		end else begin
			case (state)
				sample_buf_pkg::ST_IDLE: begin
					if (evt_start) begin
						state          <= sample_buf_pkg::ST_CAPTURE;
						cap.sel        <= '0;
						cap.sample_idx <= '0;
					end
				end
				sample_buf_pkg::ST_CAPTURE: begin
					if (last_grp) begin
						cap.sel <= '0;   // wrap to group 0
						if (last_smp) begin
							state <= sample_buf_pkg::ST_IDLE;   // event complete
						end else begin
							cap.sample_idx <= cap.sample_idx + 1'b1;
						end
					end else begin
						cap.sel <= cap.sel + 1'b1;
					end
				end
				default: begin
					state <= sample_buf_pkg::ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// checks

	a_sel_range: assert property (
		@(posedge CLK40) disable iff (srst)
		cap.sel <= sample_buf_pkg::NUM_GRP - 1
	) else $error("group select out of range");

	// tracker must hold off the next event until this one ends
	a_no_restart: assert property (
		@(posedge CLK40) disable iff (srst)
		!(evt_start && cap.active)
	) else $error("event start during active capture");

endmodule

//--- hdl/l1a_tracker.sv
module l1a_tracker (
	input  logic                             CLK40,
	input  logic                             srst,
	input  logic                             l1a,
	input  logic                             l1a_match,
	input  logic                             l1a_resync,
	input  logic                             smp_tick,
	input  logic                             hdr_rd_en,
	output logic [sample_buf_pkg::HDR_W-1:0] hdr_dout,
	output logic                             rdy,
	output logic                             evt_start,
	capture_if.mon                           cap
);

	logic [sample_buf_pkg::HDR_L1A_W-1:0]   l1a_cnt;
	logic [sample_buf_pkg::HDR_L1A_W-1:0]   l1a_nxt;
	logic [sample_buf_pkg::HDR_MATCH_W-1:0] match_cnt;
	logic [sample_buf_pkg::HDR_MATCH_W-1:0] match_nxt;
	logic [sample_buf_pkg::HDR_OPEN_W-1:0]  open_cnt;   // matched, not yet done
	logic [sample_buf_pkg::HDR_OPEN_W-1:0]  q_cnt;      // matched, not yet started
	logic [sample_buf_pkg::HDR_OPEN_W:0]    open_eff;   // includes header in flight
	logic                                   accept;
	logic                                   hdr_wr;
	logic [sample_buf_pkg::HDR_W-1:0]       hdr_din;
	logic                                   hdr_empty;

	//////////////////////////////////////////////////
	// trigger counters

	assign open_eff = {1'b0, open_cnt} + {{sample_buf_pkg::HDR_OPEN_W{1'b0}}, hdr_wr};
	assign accept   = l1a_match && (open_eff < sample_buf_pkg::MAX_OPEN);

	// next values, current pulse included
	assign l1a_nxt   = l1a_resync ? '0 :
		l1a_cnt + {{(sample_buf_pkg::HDR_L1A_W-1){1'b0}}, l1a};
	assign match_nxt = l1a_resync ? '0 :
		match_cnt + {{(sample_buf_pkg::HDR_MATCH_W-1){1'b0}}, accept};

	always_ff @(posedge CLK40 or posedge srst) begin
		if (srst) begin
			l1a_cnt   <= '0;
			match_cnt <= '0;
			hdr_wr    <= 1'b0;
			open_cnt  <= '0;
			q_cnt     <= '0;
		end else begin
			l1a_cnt   <= l1a_nxt;
			match_cnt <= match_nxt;
			hdr_wr    <= accept;   // header lands one edge after the match
			open_cnt  <= open_cnt + {3'b000, hdr_wr} - {3'b000, cap.done};
			q_cnt     <= q_cnt + {3'b000, hdr_wr} - {3'b000, evt_start};
		end
	end

	// start only on a sample boundary with the sequencer idle
	assign evt_start = smp_tick & ~cap.active & (q_cnt != 0);

	//////////////////////////////////////////////////
	// header assembly

	always_ff @(posedge CLK40) begin
		if (accept) begin
			hdr_din <= '0;
			hdr_din[sample_buf_pkg::HDR_L1A_LSB +: sample_buf_pkg::HDR_L1A_W]     <= l1a_nxt;
			hdr_din[sample_buf_pkg::HDR_MATCH_LSB +: sample_buf_pkg::HDR_MATCH_W] <= match_nxt;
			hdr_din[sample_buf_pkg::HDR_OPEN_LSB +: sample_buf_pkg::HDR_OPEN_W]   <=
				open_eff[sample_buf_pkg::HDR_OPEN_W-1:0];
			hdr_din[sample_buf_pkg::HDR_PHASE_BIT] <= smp_tick;
			hdr_din[sample_buf_pkg::HDR_OVLP_BIT]  <= (open_eff > 0);
			hdr_din[sample_buf_pkg::HDR_MOVLP_BIT] <= (open_eff > 1);
		end
	end

	sync_fifo #(
		.WIDTH (sample_buf_pkg::HDR_W),
		.DEPTH (sample_buf_pkg::HDR_DEPTH)
	) hdr_fifo_inst (
		.CLK40    (CLK40),
		.srst     (srst),
		.wr_en    (hdr_wr),
		.din      (hdr_din),
		.rd_en    (hdr_rd_en),
		.dout     (hdr_dout),
		.empty    (hdr_empty),
		.full     (),
		.overflow ()
	);

	assign rdy = ~hdr_empty;

	//////////////////////////////////////////////////
	// checks

	a_open_limit: assert property (
		@(posedge CLK40) disable iff (srst)
		open_eff <= sample_buf_pkg::MAX_OPEN
	) else $error("open event count above limit");

	// sequencer done pulses must never outrun the matches
	a_queue_subset: assert property (
		@(posedge CLK40) disable iff (srst)
		q_cnt <= open_cnt
	) else $error("queued events exceed open events");

endmodule

//--- hdl/channel_fifo_bank.sv
module channel_fifo_bank (
	input  logic                              CLK40,
	input  logic                              srst,
	input  logic [sample_buf_pkg::GRP_W-1:0]  g_in [sample_buf_pkg::NUM_GRP],
	input  logic [sample_buf_pkg::NUM_CH-1:0] ch_rd_en,
	output logic [sample_buf_pkg::GRP_W-1:0]  ch_dout,
	output logic [sample_buf_pkg::NUM_CH-1:0] ch_empty,
	output logic [sample_buf_pkg::NUM_CH-1:0] ch_ovf,
	capture_if.sink                           cap
);

	logic [sample_buf_pkg::GRP_W-1:0] grp;   // selected group bus

	//////////////////////////////////////////////////
	// group multiplexer

	always_comb begin
		grp = '0;
		for (int g = 0; g < sample_buf_pkg::NUM_GRP; g++) begin
			if (cap.sel == g) begin
				grp = g_in[g];
			end
		end
	end

	//////////////////////////////////////////////////
	// per channel fifos

	genvar k;
	generate
		for (k = 0; k < sample_buf_pkg::NUM_CH; k++) begin : g_ch
			sync_fifo #(
				.WIDTH (sample_buf_pkg::SMP_W),
				.DEPTH (sample_buf_pkg::CH_DEPTH)
			) ch_fifo_inst (
				.CLK40    (CLK40),
				.srst     (srst),
				.wr_en    (cap.wr_en),
				.din      (grp[k*sample_buf_pkg::SMP_W +: sample_buf_pkg::SMP_W]),
				.rd_en    (ch_rd_en[k]),
				.dout     (ch_dout[k*sample_buf_pkg::SMP_W +: sample_buf_pkg::SMP_W]),
				.empty    (ch_empty[k]),
				.full     (),
				.overflow (ch_ovf[k])   // sticky per channel
			);
		end
	endgenerate

endmodule

//--- hdl/sample_buf_top.sv
module sample_buf_top (
	input  logic                                CLK40,
	input  logic                                srst,
	input  logic                                l1a,
	input  logic                                l1a_match,
	input  logic                                l1a_resync,
	input  logic                                smp_tick,
	input  logic [sample_buf_pkg::SMPIDX_W-1:0] samp_max,   // samples per event minus 1
	input  logic [sample_buf_pkg::GRP_W-1:0]    g1_in,
	input  logic [sample_buf_pkg::GRP_W-1:0]    g2_in,
	input  logic [sample_buf_pkg::GRP_W-1:0]    g3_in,
	input  logic [sample_buf_pkg::GRP_W-1:0]    g4_in,
	input  logic [sample_buf_pkg::GRP_W-1:0]    g5_in,
	input  logic [sample_buf_pkg::GRP_W-1:0]    g6_in,
	input  logic [sample_buf_pkg::NUM_CH-1:0]   ch_rd_en,
	input  logic                                hdr_rd_en,
	output logic [sample_buf_pkg::GRP_W-1:0]    ch_dout,
	output logic [sample_buf_pkg::NUM_CH-1:0]   ch_empty,
	output logic [sample_buf_pkg::NUM_CH-1:0]   ch_ovf,
	output logic [sample_buf_pkg::HDR_W-1:0]    hdr_dout,
	output logic                                rdy
);

	logic                             evt_start;
	logic [sample_buf_pkg::GRP_W-1:0] g_all [sample_buf_pkg::NUM_GRP];

	// group order follows the select value
	assign g_all[0] = g1_in;
	assign g_all[1] = g2_in;
	assign g_all[2] = g3_in;
	assign g_all[3] = g4_in;
	assign g_all[4] = g5_in;
	assign g_all[5] = g6_in;

	capture_if cap ();

	l1a_tracker l1a_tracker_inst (
		.CLK40      (CLK40),
		.srst       (srst),
		.l1a        (l1a),
		.l1a_match  (l1a_match),
		.l1a_resync (l1a_resync),
		.smp_tick   (smp_tick),
		.hdr_rd_en  (hdr_rd_en),
		.hdr_dout   (hdr_dout),
		.rdy        (rdy),
		.evt_start  (evt_start),
		.cap        (cap.mon)
	);

	load_fsm load_fsm_inst (
		.CLK40     (CLK40),
		.srst      (srst),
		.evt_start (evt_start),
		.samp_max  (samp_max),
		.cap       (cap.seq)
	);

	channel_fifo_bank channel_fifo_bank_inst (
		.CLK40    (CLK40),
		.srst     (srst),
		.g_in     (g_all),
		.ch_rd_en (ch_rd_en),
		.ch_dout  (ch_dout),
		.ch_empty (ch_empty),
		.ch_ovf   (ch_ovf),
		.cap      (cap.sink)
	);

endmodule

//--- verif/sample_buf_tb.sv
module sample_buf_tb;

	logic                                   CLK40;
	logic                                   srst;
	logic                                   l1a;
	logic                                   l1a_match;
	logic                                   l1a_resync;
	logic                                   smp_tick;
	logic [sample_buf_pkg::SMPIDX_W-1:0]    samp_max;
	logic [sample_buf_pkg::GRP_W-1:0]       grp_in [sample_buf_pkg::NUM_GRP];
	logic [sample_buf_pkg::NUM_CH-1:0]      ch_rd_en;
	logic                                   hdr_rd_en;
	logic [sample_buf_pkg::GRP_W-1:0]       ch_dout;
	logic [sample_buf_pkg::NUM_CH-1:0]      ch_empty;
	logic [sample_buf_pkg::NUM_CH-1:0]      ch_ovf;
	logic [sample_buf_pkg::HDR_W-1:0]       hdr_dout;
	logic                                   rdy;
	logic [31:0]                            lfsr;
	logic [sample_buf_pkg::HDR_L1A_W-1:0]   trig_ref;   // model trigger count
	logic [sample_buf_pkg::HDR_MATCH_W-1:0] match_ref;
	int                                     open_ref;   // matched, not yet drained
	logic [sample_buf_pkg::HDR_W-1:0]       exp_hdrs [$];
	logic [sample_buf_pkg::GRP_W-1:0]       exp_rows [$];   // one row per write
	string                                  cur_test;
	int                                     err_cnt;
	int                                     err_at_start;
	int                                     test_cnt;
	int                                     check_cnt;
	int                                     wait_limit;

	always #50 CLK40 = ~CLK40;

	sample_buf_top sample_buf_top_inst (
		.*,
		.g1_in (grp_in[0]),
		.g2_in (grp_in[1]),
		.g3_in (grp_in[2]),
		.g4_in (grp_in[3]),
		.g5_in (grp_in[4]),
		.g6_in (grp_in[5])
	);

	//////////////////////////////////////////////////
	// stimulus helpers

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        b;
		val = '0;
		for (int i = 0; i < n; i++) begin
			b    = lfsr[0];
			lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);   // galois step
			val  = {val[30:0], b};
		end
		return val;
	endfunction

	function automatic logic rand_bit();
		logic [31:0] rnd;
		rnd = take_bits(1);
		return rnd[0];
	endfunction

	function automatic logic [sample_buf_pkg::HDR_W-1:0] make_header(
		input int open, input logic phase);
		logic [sample_buf_pkg::HDR_W-1:0] h;
		h = '0;
		h[sample_buf_pkg::HDR_L1A_LSB +: sample_buf_pkg::HDR_L1A_W]     = trig_ref;
		h[sample_buf_pkg::HDR_MATCH_LSB +: sample_buf_pkg::HDR_MATCH_W] = match_ref;
		h[sample_buf_pkg::HDR_OPEN_LSB +: sample_buf_pkg::HDR_OPEN_W]   = open[3:0];
		h[sample_buf_pkg::HDR_PHASE_BIT] = phase;
		h[sample_buf_pkg::HDR_OVLP_BIT]  = (open > 0);
		h[sample_buf_pkg::HDR_MOVLP_BIT] = (open > 1);
		return h;
	endfunction

	task automatic next_cycle();
		@(negedge CLK40);
		smp_tick   = rand_bit();   // sample strobe at random
		l1a        = 1'b0;
		l1a_match  = 1'b0;
		l1a_resync = 1'b0;
		hdr_rd_en  = 1'b0;
		ch_rd_en   = '0;
	endtask

	task automatic new_setup();
		logic [31:0] rnd;
		for (int g = 0; g < sample_buf_pkg::NUM_GRP; g++) begin
			for (int w = 0; w < sample_buf_pkg::GRP_W / 32; w++) begin
				grp_in[g][w*32 +: 32] = take_bits(32);
			end
		end
		rnd      = take_bits(2);
		samp_max = rnd[sample_buf_pkg::SMPIDX_W-1:0];   // one to four samples
	endtask

	// l1a pulse, with a match when asked
	task automatic send_trig(input logic match, input logic tick);
		next_cycle();
		smp_tick  = tick;
		l1a       = 1'b1;
		l1a_match = match;
		trig_ref  = trig_ref + 1'b1;
		if (match) begin
			match_ref = match_ref + 1'b1;
			exp_hdrs.push_back(make_header(open_ref, tick));
			open_ref++;
			for (int s = 0; s <= int'(samp_max); s++) begin
				for (int g = 0; g < sample_buf_pkg::NUM_GRP; g++) begin
					exp_rows.push_back(grp_in[g]);
				end
			end
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout in test %s while waiting for %s", cur_test, what);
		err_cnt++;
	endtask

	//////////////////////////////////////////////////
	// checks on the fifo heads, run where a read is driven

	task automatic pop_header();
		logic [sample_buf_pkg::HDR_W-1:0] want;
		check_cnt++;
		want = (exp_hdrs.size() > 0) ? exp_hdrs.pop_front() : 'x;
		assert (hdr_dout === want) else begin
			$display("mismatch %s header expected %h actual %h", cur_test, want, hdr_dout);
			err_cnt++;
		end
		hdr_rd_en = 1'b1;
	endtask

	task automatic pop_rows();
		logic [sample_buf_pkg::GRP_W-1:0] want;
		logic [sample_buf_pkg::SMP_W-1:0] w_ch;
		logic [sample_buf_pkg::SMP_W-1:0] g_ch;
		want = (exp_rows.size() > 0) ? exp_rows.pop_front() : 'x;
		for (int k = 0; k < sample_buf_pkg::NUM_CH; k++) begin
			check_cnt++;
			w_ch = want[k*sample_buf_pkg::SMP_W +: sample_buf_pkg::SMP_W];
			g_ch = ch_dout[k*sample_buf_pkg::SMP_W +: sample_buf_pkg::SMP_W];
			assert (g_ch === w_ch) else begin
				$display("mismatch %s ch%0d expected %h actual %h", cur_test, k, w_ch, g_ch);
				err_cnt++;
			end
		end
		ch_rd_en = '1;
	endtask

	task automatic drain(input int n_hdr, input int n_rows);
		int hdr_left;
		int row_left;
		int guard;
		hdr_left = n_hdr;
		row_left = n_rows;
		guard    = 0;
		while ((hdr_left > 0 || row_left > 0) && guard < wait_limit) begin
			next_cycle();
			if (hdr_left > 0 && rdy) begin
				pop_header();
				hdr_left--;
			end
			if (row_left > 0 && ch_empty == '0) begin
				pop_rows();
				row_left--;
			end
			guard++;
		end
		if (hdr_left > 0 || row_left > 0) begin
			timed_out("headers and channel words");
		end
		open_ref = open_ref - n_hdr;
		next_cycle();
		check_cnt++;
		assert (ch_empty == '1 && !rdy) else begin
			$display("buffers still hold data after test %s read its words", cur_test);
			err_cnt++;
		end
	endtask

	task automatic end_test();
		test_cnt++;
		$display("test %-9s done, %0d errors", cur_test, err_cnt - err_at_start);
		err_at_start = err_cnt;
	endtask

	//////////////////////////////////////////////////
	// test sequence

	initial begin
		int guard;
		lfsr = 32'h627d75aa;
		{CLK40, l1a, l1a_match, l1a_resync, smp_tick, hdr_rd_en} = '0;
		srst       = 1'b1;
		samp_max   = '0;
		ch_rd_en   = '0;
		grp_in     = '{default: '0};
		trig_ref   = '0;
		match_ref  = '0;
		open_ref   = 0;
		{err_cnt, err_at_start, test_cnt, check_cnt} = '0;
		wait_limit = 4000;
		repeat (4) @(negedge CLK40);
		srst = 1'b0;

		cur_test = "reset";
		next_cycle();
		check_cnt++;
		assert (!rdy && ch_empty == '1 && ch_ovf == '0) else begin
			$display("outputs not in their reset state after srst");
			err_cnt++;
		end
		end_test();

		cur_test = "single";
		new_setup();
		send_trig(1'b1, rand_bit());
		drain(1, exp_rows.size());
		end_test();

		cur_test = "resync";
		new_setup();
		repeat (1 + take_bits(2)) begin
			send_trig(1'b0, rand_bit());
			repeat (take_bits(2)) next_cycle();
		end
		send_trig(1'b1, rand_bit());
		drain(1, exp_rows.size());
		next_cycle();
		l1a_resync = 1'b1;
		trig_ref   = '0;
		match_ref  = '0;
		send_trig(1'b1, rand_bit());   // counts restart at 1
		drain(1, exp_rows.size());
		end_test();

		cur_test = "overlap";
		new_setup();
		send_trig(1'b1, rand_bit());
		guard = 0;
		while (ch_empty == '1 && guard < wait_limit) begin
			next_cycle();
			guard++;
		end
		if (ch_empty == '1) begin
			timed_out("start of capture");
		end
		send_trig(1'b1, rand_bit());
		send_trig(1'b1, rand_bit());
		drain(3, exp_rows.size());
		end_test();

		cur_test = "phase";
		for (int i = 0; i < 6; i++) begin
			new_setup();
			send_trig(1'b1, i[0]);
			drain(1, exp_rows.size());
		end
		end_test();

		cur_test = "overflow";
		new_setup();
		samp_max = 7'd56;   // three events give 1026 words
		repeat (3) send_trig(1'b1, rand_bit());
		guard = 0;
		while (ch_ovf != '1 && guard < wait_limit) begin
			next_cycle();
			guard++;
		end
		if (ch_ovf != '1) begin
			timed_out("channel overflow");
		end
		repeat (4) next_cycle();   // last write lands one cycle after overflow
		drain(3, sample_buf_pkg::CH_DEPTH);
		exp_rows.delete();
		check_cnt++;
		assert (ch_ovf == '1) else begin
			$display("overflow flags cleared without a reset");
			err_cnt++;
		end
		end_test();

		$display("tests run %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
hdl/sample_buf_pkg.sv
hdl/capture_if.sv
hdl/sync_fifo.sv
hdl/load_fsm.sv
hdl/l1a_tracker.sv
hdl/channel_fifo_bank.sv
hdl/sample_buf_top.sv
verif/sample_buf_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sample_buf_tb \
	-f flist.f -Mdir obj_dir -o sim_tb \
	&& ./obj_dir/sim_tb 2>&1 | tee sim.log \
	|| echo "build or simulation did not complete"
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null && echo "result: pass" && exit 0
echo "result: fail"
exit 1
